// File: src/warp_core_defines.svh
`ifndef WARP_CORE_DEFINES_SVH
`define WARP_CORE_DEFINES_SVH

// Lanes per warp and warp count
`define WC_THREADS 4
`define WC_WARPS 4
`define WC_WID_W $clog2(`WC_WARPS)

// Lane data width and register index width
`define WC_XLEN 32
`define WC_NR_BITS 5

// Instruction tag and retired counter widths
`define WC_UUID_W 8
`define WC_INSTRET_W 32

`endif

// File: src/warp_core_pkg.sv
`include "warp_core_defines.svh"

package warp_core_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_LANE = 3'd4,
        OP_HALT = 3'd5
    } op_t;

    // Request from decode to an execution unit
    typedef struct packed {
        logic [`WC_UUID_W-1:0]               uuid;
        logic [`WC_WID_W-1:0]                wid;
        logic [`WC_THREADS-1:0]              tmask;
        logic [`WC_NR_BITS-1:0]              rd;
        logic                                wb;
        logic                                eop;
        op_t                                 op;
        logic [`WC_THREADS-1:0][`WC_XLEN-1:0] rs1;
        logic [`WC_THREADS-1:0][`WC_XLEN-1:0] rs2;
    } exec_req_t;

    // Result from a unit to commit
    typedef struct packed {
        logic [`WC_UUID_W-1:0]               uuid;
        logic [`WC_WID_W-1:0]                wid;
        logic [`WC_THREADS-1:0]              tmask;
        logic [`WC_NR_BITS-1:0]              rd;
        logic                                wb;
        logic                                eop;
        logic                                halt;
        logic [`WC_THREADS-1:0][`WC_XLEN-1:0] data;
    } commit_t;

endpackage

// File: src/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     valid_q;
    payload_t data_q;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// File: src/commit_arb.sv
`timescale 1ns/1ps

module commit_arb #(
    parameter type payload_t = logic
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] in_valid,
    output logic [1:0] in_ready,
    input  payload_t   in_data [2],
    output logic       out_valid,
    input  logic       out_ready,
    output payload_t   out_data
);
    logic     valid_q;
    payload_t data_q;
    logic     prio;
    logic     sel;
    logic     slot_free;
    logic     fire;

    assign slot_free = !valid_q || out_ready;

    // Priority input wins only when both request
    always_comb begin
        if (in_valid[0] && in_valid[1]) begin
            sel = prio;
        end else begin
            sel = in_valid[1];
        end
    end

    assign in_ready[0] = slot_free && !sel;
    assign in_ready[1] = slot_free && sel;
    assign fire        = |(in_valid & in_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            prio    <= 1'b0;
        end else if (fire) begin
            valid_q <= 1'b1;
            prio    <= !sel;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            data_q <= in_data[sel];
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// File: src/warp_decode.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module warp_decode (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  warp_core_pkg::op_t                    in_op,
    input  logic [`WC_WID_W-1:0]                  in_wid,
    input  logic [`WC_THREADS-1:0]                in_tmask,
    input  logic [`WC_NR_BITS-1:0]                in_rd,
    input  logic                                  in_eop,
    input  logic [`WC_UUID_W-1:0]                 in_uuid,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0]  in_rs1,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0]  in_rs2,
    output logic                                  alu_req_valid,
    input  logic                                  alu_req_ready,
    output warp_core_pkg::exec_req_t              alu_req,
    output logic                                  sfu_req_valid,
    input  logic                                  sfu_req_ready,
    output warp_core_pkg::exec_req_t              sfu_req
);
    import warp_core_pkg::*;

    exec_req_t req_in;
    exec_req_t req_q;
    logic      req_q_valid;
    logic      req_q_ready;
    logic      to_sfu;

    always_comb begin
        req_in.uuid  = in_uuid;
        req_in.wid   = in_wid;
        req_in.tmask = in_tmask;
        req_in.rd    = in_rd;
        // Halts retire without a register write and always close the packet
        req_in.wb    = (in_rd != '0) && (in_op != OP_HALT);
        req_in.eop   = in_eop || (in_op == OP_HALT);
        req_in.op    = in_op;
        req_in.rs1   = in_rs1;
        req_in.rs2   = in_rs2;
    end

    pipe_stage #(
        .payload_t (exec_req_t)
    ) u_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (req_in),
        .out_valid (req_q_valid),
        .out_ready (req_q_ready),
        .out_data  (req_q)
    );

    // Unit select from the registered op
    assign to_sfu = (req_q.op == OP_LANE) || (req_q.op == OP_HALT);

    assign alu_req_valid = req_q_valid && !to_sfu;
    assign sfu_req_valid = req_q_valid && to_sfu;
    assign req_q_ready   = to_sfu ? sfu_req_ready : alu_req_ready;

    assign alu_req = req_q;
    assign sfu_req = req_q;

endmodule

// File: src/warp_alu.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module warp_alu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  warp_core_pkg::exec_req_t req,
    output logic                     commit_valid,
    input  logic                     commit_ready,
    output warp_core_pkg::commit_t   commit
);
    import warp_core_pkg::*;

    commit_t result;

    always_comb begin
        result.uuid  = req.uuid;
        result.wid   = req.wid;
        result.tmask = req.tmask;
        result.rd    = req.rd;
        result.wb    = req.wb;
        result.eop   = req.eop;
        result.halt  = 1'b0;
        for (int i = 0; i < `WC_THREADS; i++) begin
            if (!req.tmask[i]) begin
                result.data[i] = '0;
            end else begin
                case (req.op)
                    OP_ADD:  result.data[i] = req.rs1[i] + req.rs2[i];
                    OP_SUB:  result.data[i] = req.rs1[i] - req.rs2[i];
                    OP_AND:  result.data[i] = req.rs1[i] & req.rs2[i];
                    OP_XOR:  result.data[i] = req.rs1[i] ^ req.rs2[i];
                    default: result.data[i] = '0;
                endcase
            end
        end
    end

    // Single result register toward commit
    pipe_stage #(
        .payload_t (commit_t)
    ) u_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (result),
        .out_valid (commit_valid),
        .out_ready (commit_ready),
        .out_data  (commit)
    );

endmodule

// File: src/warp_sfu.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module warp_sfu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  warp_core_pkg::exec_req_t req,
    output logic                     commit_valid,
    input  logic                     commit_ready,
    output warp_core_pkg::commit_t   commit
);
    import warp_core_pkg::*;

    localparam int LATENCY = 3;

    exec_req_t  req_q;
    logic       busy;
    logic [1:0] count;

    // One item at a time
    assign req_ready = !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (req_valid && req_ready) begin
            busy  <= 1'b1;
            count <= 2'(LATENCY - 1);
        end else if (commit_valid && commit_ready) begin
            busy <= 1'b0;
        end else if (busy && (count != '0)) begin
            count <= count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    // Result held until commit takes it
    assign commit_valid = busy && (count == '0);

    always_comb begin
        commit.uuid  = req_q.uuid;
        commit.wid   = req_q.wid;
        commit.tmask = req_q.tmask;
        commit.rd    = req_q.rd;
        commit.wb    = req_q.wb;
        commit.eop   = req_q.eop;
        commit.halt  = (req_q.op == OP_HALT);
        for (int i = 0; i < `WC_THREADS; i++) begin
            // Global thread id of the lane
            if (req_q.tmask[i] && (req_q.op == OP_LANE)) begin
                commit.data[i] = `WC_XLEN'(req_q.wid) * `WC_XLEN'(`WC_THREADS)
                               + `WC_XLEN'(i);
            end else begin
                commit.data[i] = '0;
            end
        end
    end

endmodule

// File: src/warp_commit.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module warp_commit (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 alu_commit_valid,
    output logic                                 alu_commit_ready,
    input  warp_core_pkg::commit_t               alu_commit,
    input  logic                                 sfu_commit_valid,
    output logic                                 sfu_commit_ready,
    input  warp_core_pkg::commit_t               sfu_commit,
    output logic                                 wb_valid,
    output logic [`WC_UUID_W-1:0]                wb_uuid,
    output logic [`WC_WID_W-1:0]                 wb_wid,
    output logic [`WC_THREADS-1:0]               wb_tmask,
    output logic [`WC_NR_BITS-1:0]               wb_rd,
    output logic [`WC_THREADS-1:0][`WC_XLEN-1:0] wb_data,
    output logic                                 committed,
    output logic [`WC_WID_W-1:0]                 committed_wid,
    output logic                                 halt,
    output logic [`WC_INSTRET_W-1:0]             instret
);
    import warp_core_pkg::*;

    localparam int SIZE_W = $clog2(`WC_THREADS + 1);

    logic [1:0]        arb_in_ready;
    logic              arb_valid;
    commit_t           arb_data;
    logic              commit_fire;
    logic [SIZE_W-1:0] commit_size;
    logic              fire_r;
    logic [SIZE_W-1:0] size_r;

    commit_arb #(
        .payload_t (commit_t)
    ) u_arb (
        .clk       (clk),
        .reset     (reset),
        .in_valid  ({sfu_commit_valid, alu_commit_valid}),
        .in_ready  (arb_in_ready),
        .in_data   ('{alu_commit, sfu_commit}),
        .out_valid (arb_valid),
        .out_ready (1'b1),
        .out_data  (arb_data)
    );

    assign alu_commit_ready = arb_in_ready[0];
    assign sfu_commit_ready = arb_in_ready[1];

    // Commit never stalls
    assign commit_fire = arb_valid;

    assign wb_valid = arb_valid && arb_data.wb;
    assign wb_uuid  = arb_data.uuid;
    assign wb_wid   = arb_data.wid;
    assign wb_tmask = arb_data.tmask;
    assign wb_rd    = arb_data.rd;
    assign wb_data  = arb_data.data;

    // Scheduler report
    always_ff @(posedge clk) begin
        if (reset) begin
            committed <= 1'b0;
            halt      <= 1'b0;
        end else begin
            committed <= commit_fire && arb_data.eop;
            halt      <= commit_fire && arb_data.halt;
        end
    end

    always_ff @(posedge clk) begin
        committed_wid <= arb_data.wid;
    end

    // Active lanes of the committing instruction
    always_comb begin
        commit_size = '0;
        for (int i = 0; i < `WC_THREADS; i++) begin
            commit_size = commit_size + SIZE_W'(arb_data.tmask[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fire_r <= 1'b0;
        end else begin
            fire_r <= commit_fire;
        end
    end

    always_ff @(posedge clk) begin
        size_r <= commit_size;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (fire_r) begin
            instret <= instret + `WC_INSTRET_W'(size_r);
        end
    end

endmodule

// File: src/warp_core_top.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module warp_core_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  warp_core_pkg::op_t                   in_op,
    input  logic [`WC_WID_W-1:0]                 in_wid,
    input  logic [`WC_THREADS-1:0]               in_tmask,
    input  logic [`WC_NR_BITS-1:0]               in_rd,
    input  logic                                 in_eop,
    input  logic [`WC_UUID_W-1:0]                in_uuid,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0] in_rs1,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0] in_rs2,
    output logic                                 wb_valid,
    output logic [`WC_UUID_W-1:0]                wb_uuid,
    output logic [`WC_WID_W-1:0]                 wb_wid,
    output logic [`WC_THREADS-1:0]               wb_tmask,
    output logic [`WC_NR_BITS-1:0]               wb_rd,
    output logic [`WC_THREADS-1:0][`WC_XLEN-1:0] wb_data,
    output logic                                 committed,
    output logic [`WC_WID_W-1:0]                 committed_wid,
    output logic                                 halt,
    output logic [`WC_INSTRET_W-1:0]             instret
);
    import warp_core_pkg::*;

    logic      alu_req_valid;
    logic      alu_req_ready;
    exec_req_t alu_req;
    logic      sfu_req_valid;
    logic      sfu_req_ready;
    exec_req_t sfu_req;
    logic      alu_commit_valid;
    logic      alu_commit_ready;
    commit_t   alu_commit;
    logic      sfu_commit_valid;
    logic      sfu_commit_ready;
    commit_t   sfu_commit;

    warp_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_wid        (in_wid),
        .in_tmask      (in_tmask),
        .in_rd         (in_rd),
        .in_eop        (in_eop),
        .in_uuid       (in_uuid),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .alu_req_valid (alu_req_valid),
        .alu_req_ready (alu_req_ready),
        .alu_req       (alu_req),
        .sfu_req_valid (sfu_req_valid),
        .sfu_req_ready (sfu_req_ready),
        .sfu_req       (sfu_req)
    );

    warp_alu u_alu (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (alu_req_valid),
        .req_ready    (alu_req_ready),
        .req          (alu_req),
        .commit_valid (alu_commit_valid),
        .commit_ready (alu_commit_ready),
        .commit       (alu_commit)
    );

    warp_sfu u_sfu (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (sfu_req_valid),
        .req_ready    (sfu_req_ready),
        .req          (sfu_req),
        .commit_valid (sfu_commit_valid),
        .commit_ready (sfu_commit_ready),
        .commit       (sfu_commit)
    );

    warp_commit u_commit (
        .clk              (clk),
        .reset            (reset),
        .alu_commit_valid (alu_commit_valid),
        .alu_commit_ready (alu_commit_ready),
        .alu_commit       (alu_commit),
        .sfu_commit_valid (sfu_commit_valid),
        .sfu_commit_ready (sfu_commit_ready),
        .sfu_commit       (sfu_commit),
        .wb_valid         (wb_valid),
        .wb_uuid          (wb_uuid),
        .wb_wid           (wb_wid),
        .wb_tmask         (wb_tmask),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data),
        .committed        (committed),
        .committed_wid    (committed_wid),
        .halt             (halt),
        .instret          (instret)
    );

endmodule

// File: bench/commit_checker.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module commit_checker (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 in_valid,
    input  logic                                 in_ready,
    input  warp_core_pkg::op_t                   in_op,
    input  logic [`WC_WID_W-1:0]                 in_wid,
    input  logic [`WC_THREADS-1:0]               in_tmask,
    input  logic [`WC_NR_BITS-1:0]               in_rd,
    input  logic                                 in_eop,
    input  logic [`WC_UUID_W-1:0]                in_uuid,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0] in_rs1,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0] in_rs2,
    input  logic                                 wb_valid,
    input  logic [`WC_UUID_W-1:0]                wb_uuid,
    input  logic [`WC_WID_W-1:0]                 wb_wid,
    input  logic [`WC_THREADS-1:0]               wb_tmask,
    input  logic [`WC_NR_BITS-1:0]               wb_rd,
    input  logic [`WC_THREADS-1:0][`WC_XLEN-1:0] wb_data,
    input  logic                                 committed,
    input  logic [`WC_WID_W-1:0]                 committed_wid,
    input  logic                                 halt,
    input  logic [`WC_INSTRET_W-1:0]             instret,
    input  logic                                 final_check,
    output int                                   outstanding,
    output logic                                 instret_match,
    output int                                   err_reset,
    output int                                   err_alu,
    output int                                   err_lane,
    output int                                   err_wb,
    output int                                   err_sched,
    output int                                   err_instret
);
    import warp_core_pkg::*;

    localparam int TAGS = 1 << `WC_UUID_W;

    // Expected writeback per uuid
    logic [`WC_THREADS-1:0][`WC_XLEN-1:0] exp_data [TAGS];
    logic [`WC_WID_W-1:0]                 exp_wid [TAGS];
    logic [`WC_THREADS-1:0]               exp_tmask [TAGS];
    logic [`WC_NR_BITS-1:0]               exp_rd [TAGS];
    logic                                 exp_lane [TAGS];
    logic                                 wb_pending [TAGS];

    int                       halts_pending [`WC_WARPS];
    int                       eops_pending [`WC_WARPS];
    int                       wb_outstanding = 0;
    int                       eop_expected = 0;
    int                       eop_seen = 0;
    logic [`WC_INSTRET_W-1:0] exp_instret = '0;
    logic                     rst_d = 1'b0;

    int n_reset = 0;
    int n_alu = 0;
    int n_lane = 0;
    int n_wb = 0;
    int n_sched = 0;
    int n_instret = 0;

    assign outstanding   = wb_outstanding + eop_expected - eop_seen;
    assign instret_match = (instret == exp_instret);
    assign err_reset     = n_reset;
    assign err_alu       = n_alu;
    assign err_lane      = n_lane;
    assign err_wb        = n_wb;
    assign err_sched     = n_sched;
    assign err_instret   = n_instret;

    // Lane value as the ISA defines it
    function automatic logic [`WC_XLEN-1:0] expected_lane(input op_t op,
                                                          input logic [`WC_WID_W-1:0] wid,
                                                          input int lane,
                                                          input logic [`WC_XLEN-1:0] a,
                                                          input logic [`WC_XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_LANE: return `WC_XLEN'(int'(wid) * `WC_THREADS + lane);
            default: return '0;
        endcase
    endfunction

    task automatic expect_zero(input string name, input logic [31:0] got);
        if (got !== '0) begin
            $display("mismatch %s in reset: got 0x%h expected 0x0", name, got);
            n_reset++;
        end
    endtask

    task automatic record_instruction();
        logic [`WC_UUID_W-1:0] u;
        logic                  wb;
        u  = in_uuid;
        wb = (in_rd != '0) && (in_op != OP_HALT);
        exp_instret = exp_instret + `WC_INSTRET_W'($countones(in_tmask));
        if (in_eop || (in_op == OP_HALT)) begin
            eop_expected++;
            eops_pending[in_wid]++;
        end
        if (in_op == OP_HALT) begin
            halts_pending[in_wid]++;
        end
        if (wb) begin
            if (wb_pending[u]) begin
                $display("uuid 0x%h issued again while its writeback is still pending", u);
                n_wb++;
            end else begin
                wb_outstanding++;
            end
            wb_pending[u] = 1'b1;
            exp_wid[u]    = in_wid;
            exp_tmask[u]  = in_tmask;
            exp_rd[u]     = in_rd;
            exp_lane[u]   = (in_op == OP_LANE);
            for (int i = 0; i < `WC_THREADS; i++) begin
                exp_data[u][i] = in_tmask[i] ?
                    expected_lane(in_op, in_wid, i, in_rs1[i], in_rs2[i]) : '0;
            end
        end
    endtask

    task automatic check_writeback();
        logic [`WC_UUID_W-1:0] u;
        int                    errs;
        u    = wb_uuid;
        errs = 0;
        if (!wb_pending[u]) begin
            $display("writeback of uuid 0x%h that was filtered, already written or not issued",
                     u);
            n_wb++;
        end else begin
            wb_pending[u] = 1'b0;
            wb_outstanding--;
            if (wb_wid !== exp_wid[u]) begin
                $display("mismatch wb_wid uuid 0x%h: got 0x%h expected 0x%h",
                         u, wb_wid, exp_wid[u]);
                errs++;
            end
            if (wb_tmask !== exp_tmask[u]) begin
                $display("mismatch wb_tmask uuid 0x%h: got 0x%h expected 0x%h",
                         u, wb_tmask, exp_tmask[u]);
                errs++;
            end
            if (wb_rd !== exp_rd[u]) begin
                $display("mismatch wb_rd uuid 0x%h: got 0x%h expected 0x%h",
                         u, wb_rd, exp_rd[u]);
                errs++;
            end
            for (int i = 0; i < `WC_THREADS; i++) begin
                if (wb_data[i] !== exp_data[u][i]) begin
                    $display("mismatch wb_data[%0d] uuid 0x%h: got 0x%h expected 0x%h",
                             i, u, wb_data[i], exp_data[u][i]);
                    errs++;
                end
            end
            if (exp_lane[u]) begin
                n_lane += errs;
            end else begin
                n_alu += errs;
            end
        end
    endtask

    task automatic check_report();
        if (committed) begin
            eop_seen++;
            if (eops_pending[committed_wid] == 0) begin
                $display("committed pulse for warp 0x%h with no end-of-packet instruction in flight",
                         committed_wid);
                n_sched++;
            end else begin
                eops_pending[committed_wid]--;
            end
        end
        if (halt) begin
            if (!committed) begin
                $display("halt pulse without a committed pulse in the same cycle");
                n_sched++;
            end
            if (halts_pending[committed_wid] == 0) begin
                $display("halt reported for warp 0x%h which has no halt in flight",
                         committed_wid);
                n_sched++;
            end else begin
                halts_pending[committed_wid]--;
            end
        end
    endtask

    task automatic check_final();
        if (instret !== exp_instret) begin
            $display("mismatch instret: got 0x%h expected 0x%h", instret, exp_instret);
            n_instret++;
        end
        if (wb_outstanding != 0) begin
            $display("%0d expected writebacks never arrived", wb_outstanding);
            n_wb++;
        end
        if (eop_seen != eop_expected) begin
            $display("mismatch committed count: got 0x%h expected 0x%h",
                     eop_seen, eop_expected);
            n_sched++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TAGS; i++) begin
                wb_pending[i] = 1'b0;
            end
            for (int w = 0; w < `WC_WARPS; w++) begin
                halts_pending[w] = 0;
                eops_pending[w]  = 0;
            end
            wb_outstanding = 0;
            eop_expected   = 0;
            eop_seen       = 0;
            exp_instret    = '0;
        end
        // Outputs must show the reset state from the second reset edge on
        if (rst_d) begin
            expect_zero("wb_valid", 32'(wb_valid));
            expect_zero("committed", 32'(committed));
            expect_zero("halt", 32'(halt));
            expect_zero("instret", 32'(instret));
        end
        if (!reset) begin
            if (wb_valid) begin
                check_writeback();
            end
            if (committed || halt) begin
                check_report();
            end
            if (in_valid && in_ready) begin
                record_instruction();
            end
            if (final_check) begin
                check_final();
            end
        end
        rst_d = reset;
    end

endmodule

// File: bench/tb_warp_core.sv
`timescale 1ns/1ps
`include "warp_core_defines.svh"

module tb_warp_core;
    import warp_core_pkg::*;

    parameter int SEED = 92;

    localparam int NUM_INSTR     = 300;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 500;

    logic                                 clk;
    logic                                 reset;
    logic                                 in_valid;
    logic                                 in_ready;
    op_t                                  in_op;
    logic [`WC_WID_W-1:0]                 in_wid;
    logic [`WC_THREADS-1:0]               in_tmask;
    logic [`WC_NR_BITS-1:0]               in_rd;
    logic                                 in_eop;
    logic [`WC_UUID_W-1:0]                in_uuid;
    logic [`WC_THREADS-1:0][`WC_XLEN-1:0] in_rs1;
    logic [`WC_THREADS-1:0][`WC_XLEN-1:0] in_rs2;
    logic                                 wb_valid;
    logic [`WC_UUID_W-1:0]                wb_uuid;
    logic [`WC_WID_W-1:0]                 wb_wid;
    logic [`WC_THREADS-1:0]               wb_tmask;
    logic [`WC_NR_BITS-1:0]               wb_rd;
    logic [`WC_THREADS-1:0][`WC_XLEN-1:0] wb_data;
    logic                                 committed;
    logic [`WC_WID_W-1:0]                 committed_wid;
    logic                                 halt;
    logic [`WC_INSTRET_W-1:0]             instret;

    logic final_check;
    int   outstanding;
    logic instret_match;
    int   err_reset;
    int   err_alu;
    int   err_lane;
    int   err_wb;
    int   err_sched;
    int   err_instret;

    integer                seed;
    logic [`WC_UUID_W-1:0] uuid;
    int                    failed_tests;
    int                    issued;
    bit                    aborted;

    warp_core_top DUT (.*);

    commit_checker u_checker (.*);

    always #20 clk = ~clk;

    task automatic set_random_fields();
        logic [31:0] r;
        logic [2:0]  op_sel;
        r = $random(seed);
        // Roughly one halt in sixteen
        if (r[3:0] == 4'd0) begin
            in_op = OP_HALT;
        end else begin
            op_sel = 3'((r >> 4) % 5);
            in_op  = op_t'(op_sel);
        end
        in_wid   = r[8 +: `WC_WID_W];
        in_tmask = r[12 +: `WC_THREADS];
        in_rd    = (r[16 +: 3] == 3'd0) ? '0 : r[20 +: `WC_NR_BITS];
        in_eop   = r[25];
        for (int i = 0; i < `WC_THREADS; i++) begin
            in_rs1[i] = $random(seed);
            in_rs2[i] = $random(seed);
        end
    endtask

    task automatic issue_instruction(output bit timed_out);
        logic [31:0] r;
        int          gap;
        int          waited;
        r   = $random(seed);
        gap = (r[3:2] == 2'b00) ? int'(r[1:0]) + 1 : 0;
        repeat (gap) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        @(negedge clk);
        set_random_fields();
        in_uuid  = uuid;
        in_valid = 1'b1;
        waited   = 0;
        @(posedge clk);
        while (!in_ready && waited < READY_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        timed_out = (in_ready !== 1'b1);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
            failed_tests++;
        end
    endtask

    initial begin
        bit timed_out;
        int waited;
        seed         = SEED;
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = OP_ADD;
        in_wid       = '0;
        in_tmask     = '0;
        in_rd        = '0;
        in_eop       = 1'b0;
        in_uuid      = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        final_check  = 1'b0;
        uuid         = '0;
        failed_tests = 0;
        issued       = 0;
        aborted      = 1'b0;

        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        report_test("reset_state", err_reset);

        for (int n = 0; n < NUM_INSTR && !aborted; n++) begin
            issue_instruction(timed_out);
            if (timed_out) begin
                $display("timeout: in_ready stayed low for %0d cycles at uuid 0x%h",
                         READY_TIMEOUT, uuid);
                aborted = 1'b1;
            end else begin
                uuid++;
                issued++;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        // Drain until every result and the retired count have arrived
        waited = 0;
        while (!(outstanding == 0 && instret_match) && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!(outstanding == 0 && instret_match)) begin
            $display("timeout: %0d results still outstanding after %0d cycles of drain",
                     outstanding, DRAIN_TIMEOUT);
            aborted = 1'b1;
        end
        final_check = 1'b1;
        @(negedge clk);
        final_check = 1'b0;

        report_test("alu_results", err_alu);
        report_test("lane_id", err_lane);
        report_test("writeback_filter", err_wb);
        report_test("scheduler_report", err_sched);
        report_test("instret", err_instret);
        $display("summary: 6 tests, %0d failed, %0d instructions issued, aborted %0d",
                 failed_tests, issued, aborted);
        if (failed_tests == 0 && !aborted) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: warp_core.f
+incdir+src
src/warp_core_pkg.sv
src/pipe_stage.sv
src/commit_arb.sv
src/warp_decode.sv
src/warp_alu.sv
src/warp_sfu.sv
src/warp_commit.sv
src/warp_core_top.sv
bench/commit_checker.sv
bench/tb_warp_core.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_warp_core
FILELIST   ?= warp_core.f
BUILD_DIR  ?= obj_dir
SEED_FLAGS ?=
PASS_TEXT  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) $(SEED_FLAGS) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
